// File: common/router_pkg.sv
// Shared router types; rows grow southward, columns grow eastward, tile id is address bits 31:24
`default_nettype none

package router_pkg;

    // ====================
    // Port naming
    // ====================

    // One port of a tile, also used as the lookahead route tag
    typedef enum logic [2:0] {
        NULL_CARDINAL = 3'd0,
        NORTH         = 3'd1,
        EAST          = 3'd2,
        SOUTH         = 3'd3,
        WEST          = 3'd4,
        LOCAL         = 3'd5
    } t_cardinal;

    // Port index order: north, east, south, west, local
    localparam int NUM_PORTS = 5;
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);

    // One bit per port, and one port number
    typedef logic [NUM_PORTS-1:0]  t_port_mask;
    typedef logic [PORT_IDX_W-1:0] t_port_idx;

    // Tile coordinate, same layout as address bits 31:24
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
    } t_tile_id;

    // ====================
    // Link types
    // ====================

    // Request side of one write-only Wishbone classic link
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
        logic [31:0] dat;
        // Sideband tag: output to take in the receiving tile
        t_cardinal   card;
    } t_wb_req;

    typedef struct packed {
        logic ack;
    } t_wb_rsp;

    // Input FIFO entry, 67 bits
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        t_cardinal   card;
    } t_fifo_entry;

    // Port index of a cardinal, NULL_CARDINAL folds onto north
    function automatic int port_of(input t_cardinal card);
        case (card)
            NORTH:   return 0;
            EAST:    return 1;
            SOUTH:   return 2;
            WEST:    return 3;
            LOCAL:   return 4;
            default: return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/router_tile.sv
// One mesh tile router; local_tile_id is a static strap and must not change after reset
`default_nettype none

module router_tile #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  router_pkg::t_tile_id                          local_tile_id,
    input  router_pkg::t_wb_req [router_pkg::NUM_PORTS-1:0] in_req,
    output router_pkg::t_wb_rsp [router_pkg::NUM_PORTS-1:0] in_rsp,
    output router_pkg::t_wb_req [router_pkg::NUM_PORTS-1:0] out_req,
    input  router_pkg::t_wb_rsp [router_pkg::NUM_PORTS-1:0] out_rsp
);
    import router_pkg::*;

    // Cardinal of each port index, north at index 0
    localparam t_cardinal [NUM_PORTS-1:0] PORT_CARD = {LOCAL, WEST, SOUTH, EAST, NORTH};
    localparam int LOCAL_PORT = port_of(LOCAL);

    // FIFO heads
    logic [NUM_PORTS-1:0]        head_valid;
    t_fifo_entry [NUM_PORTS-1:0] heads;
    t_cardinal [NUM_PORTS-1:0]   route_card;

    // Pops, indexed [output][input] and transposed [input][output]
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] pop_by_out;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] pop_by_in;
    logic [NUM_PORTS-1:0]                pop;

    // Lookahead inputs and results, indexed [instance][input]
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0]      la_valid;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0][7:0] la_adr;
    t_cardinal [NUM_PORTS-1:0][NUM_PORTS-1:0] la_card;
    t_cardinal [NUM_PORTS-1:0][NUM_PORTS-1:0] arb_card;

    // ====================
    // Input side
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        // Local requests get their tag here, transit requests bring one
        if (p == LOCAL_PORT) begin : g_card
            assign route_card[p] = la_card[LOCAL_PORT][p];
        end else begin : g_card
            assign route_card[p] = in_req[p].card;
        end

        router_in_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_in_fifo (
            .clk        (clk),
            .rst_n      (rst_n),
            .wb_req     (in_req[p]),
            .wb_rsp     (in_rsp[p]),
            .route_card (route_card[p]),
            .head_valid (head_valid[p]),
            .head       (heads[p]),
            .pop        (pop[p])
        );

        // Any output may pop this FIFO, only one does at a time
        for (genvar k = 0; k < NUM_PORTS; k++) begin : g_pop
            assign pop_by_in[p][k] = pop_by_out[k][p];
        end
        assign pop[p] = |pop_by_in[p];
    end

    // ====================
    // Lookahead and output side
    // ====================
    for (genvar k = 0; k < NUM_PORTS; k++) begin : g_out
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_slot
            if ((k == LOCAL_PORT) && (p == LOCAL_PORT)) begin : g_sel
                // Incoming local request, routed in this tile before it is stored
                assign la_valid[k][p] = in_req[p].cyc && in_req[p].stb;
                assign la_adr[k][p]   = in_req[p].adr[31:24];
                // Local loopback leaves only when tagged LOCAL, and stays LOCAL
                assign arb_card[k][p] = heads[p].card;
            end else begin : g_sel
                assign la_valid[k][p] = head_valid[p];
                assign la_adr[k][p]   = heads[p].adr[31:24];
                assign arb_card[k][p] = la_card[k][p];
            end
        end

        next_tile_fifo_arb #(
            .NEXT_TILE_CARDINAL (PORT_CARD[k])
        ) u_next_tile (
            .local_tile_id (local_tile_id),
            .req_valid     (la_valid[k]),
            .req_address   (la_adr[k]),
            .next_card     (la_card[k])
        );

        router_out_arb #(
            .OUT_CARDINAL (PORT_CARD[k])
        ) u_out_arb (
            .clk        (clk),
            .rst_n      (rst_n),
            .head_valid (head_valid),
            .heads      (heads),
            .next_card  (arb_card[k]),
            .pop        (pop_by_out[k]),
            .wb_req     (out_req[k]),
            .wb_rsp     (out_rsp[k])
        );
    end

endmodule

`default_nettype wire

// File: router/next_tile_fifo_arb.sv
// Lookahead route for one neighbour; ids wrap at the mesh edge, so edge tiles must not route outward
`default_nettype none

module next_tile_fifo_arb #(
    parameter router_pkg::t_cardinal NEXT_TILE_CARDINAL = router_pkg::NULL_CARDINAL
) (
    input  router_pkg::t_tile_id                            local_tile_id,
    input  logic [router_pkg::NUM_PORTS-1:0]                req_valid,
    input  logic [router_pkg::NUM_PORTS-1:0][7:0]           req_address,
    output router_pkg::t_cardinal [router_pkg::NUM_PORTS-1:0] next_card
);
    import router_pkg::*;

    // Tile id of the neighbour this block works for
    t_tile_id next_tile_id;

    // ====================
    // Neighbour tile id
    // ====================

    // Row 0 is the top row, so north steps the row down
    always_comb begin
        next_tile_id = local_tile_id;
        case (NEXT_TILE_CARDINAL)
            NORTH: begin
                next_tile_id.row = local_tile_id.row - 4'd1;
            end
            SOUTH: begin
                next_tile_id.row = local_tile_id.row + 4'd1;
            end
            EAST: begin
                next_tile_id.col = local_tile_id.col + 4'd1;
            end
            WEST: begin
                next_tile_id.col = local_tile_id.col - 4'd1;
            end
            // LOCAL routes the tile itself
            default: begin
                next_tile_id = local_tile_id;
            end
        endcase
    end

    // ====================
    // Row-first route
    // ====================

    // Priority mux per input
    // Rows are settled first, then columns, then local delivery
    always_comb begin
        t_tile_id dest;
        dest = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            dest = req_address[i];
            if (!req_valid[i]) begin
                next_card[i] = NULL_CARDINAL;
            end else if (dest.row < next_tile_id.row) begin
                next_card[i] = NORTH;
            end else if (dest.row > next_tile_id.row) begin
                next_card[i] = SOUTH;
            end else if (dest.col < next_tile_id.col) begin
                next_card[i] = WEST;
            end else if (dest.col > next_tile_id.col) begin
                next_card[i] = EAST;
            end else begin
                // Same row and column, deliver in that tile
                next_card[i] = LOCAL;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    // An empty slot never carries a route tag, the arbiters rely on it
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            assert (req_valid[i] || (next_card[i] == NULL_CARDINAL))
                else $error("lookahead tag on invalid input %0d", i);
        end
    end

endmodule

`default_nettype wire

// File: router/router_in_fifo.sv
// Input FIFO and Wishbone slave; FIFO_DEPTH must be a power of two, at most one ack every 2 cycles
`default_nettype none

module router_in_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  router_pkg::t_wb_req    wb_req,
    output router_pkg::t_wb_rsp    wb_rsp,
    input  router_pkg::t_cardinal  route_card,
    output logic                   head_valid,
    output router_pkg::t_fifo_entry head,
    input  logic                   pop
);
    import router_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Storage, no reset on payload
    t_fifo_entry mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from an empty one
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             ack_q;

    assign full  = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Accept when space exists and the last cycle was not our ack
    // The master drops or changes stb on the cycle after ack
    assign wr_en = wb_req.cyc && wb_req.stb && !full && !ack_q;

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= wr_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry keeps the route tag for this tile
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= '{adr: wb_req.adr, dat: wb_req.dat, card: route_card};
        end
    end

    assign wb_rsp     = '{ack: ack_q};
    assign head_valid = !empty;
    assign head       = mem[rd_ptr];

    // ====================
    // Checks
    // ====================

    // Pops come from the output arbiters
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

    // A request that meets a full buffer is not acked
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && full) |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// File: router/router_out_arb.sv
// Output round-robin arbiter and Wishbone master; one transfer in flight, one idle cycle after ack
`default_nettype none

module router_out_arb #(
    parameter router_pkg::t_cardinal OUT_CARDINAL = router_pkg::NORTH
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [router_pkg::NUM_PORTS-1:0]                  head_valid,
    input  router_pkg::t_fifo_entry [router_pkg::NUM_PORTS-1:0] heads,
    input  router_pkg::t_cardinal [router_pkg::NUM_PORTS-1:0]   next_card,
    output logic [router_pkg::NUM_PORTS-1:0]                  pop,
    output router_pkg::t_wb_req                               wb_req,
    input  router_pkg::t_wb_rsp                               wb_rsp
);
    import router_pkg::*;

    // Heads that want this output
    t_port_mask eligible;

    // Round-robin pick
    logic       pick_valid;
    t_port_idx  pick_idx;
    t_port_idx  last_grant;

    // Transfer in flight
    logic        busy;
    t_port_idx   cur_idx;
    logic [31:0] req_adr;
    logic [31:0] req_dat;
    t_cardinal   req_card;

    // ====================
    // Eligibility
    // ====================
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            eligible[i] = head_valid[i] && (heads[i].card == OUT_CARDINAL);
        end
    end

    // Scan starts one past the last grant and wraps
    always_comb begin
        int idx;
        idx        = 0;
        pick_valid = 1'b0;
        pick_idx   = last_grant;
        for (int off = 1; off <= NUM_PORTS; off++) begin
            idx = (int'(last_grant) + off) % NUM_PORTS;
            if (!pick_valid && eligible[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = t_port_idx'(idx);
            end
        end
    end

    // ====================
    // Control state
    // ====================

    // Pointer starts at this output's own port, which staggers the outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            cur_idx    <= '0;
            last_grant <= t_port_idx'(port_of(OUT_CARDINAL));
        end else if (!busy) begin
            if (pick_valid) begin
                busy       <= 1'b1;
                cur_idx    <= pick_idx;
                last_grant <= pick_idx;
            end
        end else if (wb_rsp.ack) begin
            busy <= 1'b0;
        end
    end

    // Payload captured with the grant and held until ack
    always_ff @(posedge clk) begin
        if (!busy && pick_valid) begin
            req_adr  <= heads[pick_idx].adr;
            req_dat  <= heads[pick_idx].dat;
            // Tag for the neighbour on this output
            req_card <= next_card[pick_idx];
        end
    end

    // Pop the granted FIFO on the ack cycle
    always_comb begin
        pop = '0;
        if (busy && wb_rsp.ack) begin
            pop[cur_idx] = 1'b1;
        end
    end

    assign wb_req = '{cyc: busy, stb: busy, adr: req_adr, dat: req_dat, card: req_card};

    // ====================
    // Checks
    // ====================

    // Classic bus hold: payload is frozen until the slave acks
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> ($stable(wb_req.adr) && $stable(wb_req.dat)));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module router_tb

# A fatal stop returns nonzero, the search below decides the result
sim_out=$(./obj_dir/Vrouter_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
    exit 0
else
    exit 1
fi

// File: tb.f
common/router_pkg.sv
router/next_tile_fifo_arb.sv
router/router_in_fifo.sv
router/router_out_arb.sv
design/router_tile.sv
testbench/router_tb.sv

// File: testbench/router_tb.sv
// Drives tile [2,2] and plays all four neighbours and the local core; stops at the first mismatch
`default_nettype none

module router_tb;
    import router_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam t_tile_id TILE = '{col: 4'd2, row: 4'd2};
    // Cycles a driver waits for one input ack
    localparam int ACK_LIMIT = 200;
    // Cycles with no ack that count as a stalled input
    localparam int STALL_LIMIT = 40;

    // One transfer as seen on an output, or as expected there
    typedef struct packed {
        t_cardinal   port;
        logic [31:0] adr;
        logic [31:0] dat;
        t_cardinal   card;
    } t_xfer;

    logic                            clk;
    logic                            rst_n;
    t_tile_id                        local_tile_id;
    t_wb_req [NUM_PORTS-1:0]         in_req;
    t_wb_rsp [NUM_PORTS-1:0]         in_rsp;
    t_wb_req [NUM_PORTS-1:0]         out_req;
    t_wb_rsp [NUM_PORTS-1:0]         out_rsp;

    // Expected transfers per source input, in send order
    t_xfer exp_q [NUM_PORTS][$];
    // Transfers seen by the responders, waiting for the compare process
    t_xfer obs_q [$];

    logic [NUM_PORTS-1:0] hold;
    int                   seq [NUM_PORTS];
    logic [15:0]          lfsr_state = 16'd60960;
    string                test_name = "reset_idle";
    bit                   sim_done = 1'b0;

    router_tile #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .local_tile_id (local_tile_id),
        .in_req        (in_req),
        .in_rsp        (in_rsp),
        .out_req       (out_req),
        .out_rsp       (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic t_cardinal card_of(input int idx);
        case (idx)
            0:       return NORTH;
            1:       return EAST;
            2:       return SOUTH;
            3:       return WEST;
            default: return LOCAL;
        endcase
    endfunction

    // Rows grow southward, columns grow eastward
    function automatic t_tile_id neighbour_of(input t_cardinal dir);
        t_tile_id t;
        t = TILE;
        case (dir)
            NORTH:   t.row = TILE.row - 4'd1;
            SOUTH:   t.row = TILE.row + 4'd1;
            EAST:    t.col = TILE.col + 4'd1;
            WEST:    t.col = TILE.col - 4'd1;
            default: t = TILE;
        endcase
        return t;
    endfunction

    // Reference route, row first then column then local delivery
    function automatic t_cardinal expected_route(input t_tile_id here, input logic [31:0] adr);
        t_tile_id dest;
        dest = t_tile_id'(adr[31:24]);
        if (dest.row != here.row) begin
            return (dest.row < here.row) ? NORTH : SOUTH;
        end
        if (dest.col != here.col) begin
            return (dest.col < here.col) ? WEST : EAST;
        end
        return LOCAL;
    endfunction

    function automatic logic [31:0] make_addr(input t_tile_id t);
        return {t, 24'(rand_bits(24))};
    endfunction

    function automatic bit queues_empty();
        bit empty;
        empty = (obs_q.size() == 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            empty = empty && (exp_q[p].size() == 0);
        end
        return empty;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s in test %s", msg, test_name);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // ====================
    // Compare tasks
    // ====================
    task automatic check_card(input string what, input t_cardinal exp, input t_cardinal act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %s, actual %s", test_name, what, exp.name(),
                act.name());
            stop_on_error("wrong cardinal");
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_on_error("wrong word");
        end
    endtask

    // Source input rides in dat[31:28], order is checked per source
    task automatic compare_one(input t_xfer o);
        int    src;
        t_xfer e;
        src = int'(o.dat[31:28]);
        if (src >= NUM_PORTS) begin
            stop_on_error("output transfer carries an unknown source tag");
        end else if (exp_q[src].size() == 0) begin
            stop_on_error("an output delivered a request that was never sent");
        end else begin
            e = exp_q[src].pop_front();
            check_card("output port", e.port, o.port);
            check_card("lookahead card", e.card, o.card);
            check_word("adr", e.adr, o.adr);
            check_word("dat", e.dat, o.dat);
        end
    endtask

    // ====================
    // Driver side
    // ====================

    // Expected output port and card for the request just acked on input p
    task automatic record_expected(input int p);
        t_xfer e;
        e.adr  = in_req[p].adr;
        e.dat  = in_req[p].dat;
        e.port = (p == 4) ? expected_route(TILE, e.adr) : in_req[p].card;
        e.card = expected_route(neighbour_of(e.port), e.adr);
        exp_q[p].push_back(e);
    endtask

    task automatic wait_ack(input int p, input int limit, output bit acked);
        int cycles;
        acked  = 1'b0;
        cycles = 0;
        while (!acked && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (in_rsp[p].ack) begin
                acked = 1'b1;
                record_expected(p);
                in_req[p].cyc = 1'b0;
                in_req[p].stb = 1'b0;
            end
        end
    endtask

    task automatic send_one(input int p, input logic [31:0] adr, input t_cardinal card,
                            input int limit, output bit acked);
        in_req[p].cyc  = 1'b1;
        in_req[p].stb  = 1'b1;
        in_req[p].adr  = adr;
        in_req[p].dat  = {4'(p), 12'(seq[p]), 16'(rand_bits(16))};
        in_req[p].card = card;
        seq[p]++;
        wait_ack(p, limit, acked);
    endtask

    task automatic send_ok(input int p, input logic [31:0] adr, input t_cardinal card);
        bit        acked;
        t_cardinal in_port;
        in_port = card_of(p);
        send_one(p, adr, card, ACK_LIMIT, acked);
        if (!acked) begin
            stop_on_error($sformatf("input %s never acked a request", in_port.name()));
        end
    endtask

    // NULL_CARDINAL picks a random card, local sends for SOUTH stay south of this tile
    task automatic burst(input int p, input int n, input t_cardinal card);
        t_tile_id  t;
        t_cardinal c;
        for (int i = 0; i < n; i++) begin
            t = t_tile_id'(rand_bits(8));
            if (p == 4 && card == SOUTH) begin
                t.row = 4'(3 + int'(rand_bits(4)) % 13);
            end
            c = (card == NULL_CARDINAL) ? card_of(int'(rand_bits(3)) % 5) : card;
            send_ok(p, make_addr(t), (p == 4) ? NULL_CARDINAL : c);
        end
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (!queues_empty() && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!queues_empty()) begin
            stop_on_error("requests were not all delivered before the timeout");
        end
    endtask

    // ====================
    // Responder side
    // ====================
    task automatic wait_release(input int k);
        int cycles;
        cycles = 0;
        while (hold[k] && cycles < 3000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (hold[k]) begin
            stop_on_error("an output stayed held past its timeout");
        end
    endtask

    task automatic respond(input int k);
        int    delay;
        t_xfer o;
        while (!sim_done) begin
            @(posedge clk);
            #1;
            if (out_req[k].stb) begin
                wait_release(k);
                delay = int'(rand_bits(2));
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                o.port = card_of(k);
                o.adr  = out_req[k].adr;
                o.dat  = out_req[k].dat;
                o.card = out_req[k].card;
                obs_q.push_back(o);
                out_rsp[k].ack = 1'b1;
                @(posedge clk);
                #1;
                out_rsp[k].ack = 1'b0;
            end
        end
    endtask

    initial begin
        fork
            respond(0);
            respond(1);
            respond(2);
            respond(3);
            respond(4);
        join
    end

    // Compare runs after drivers and responders in each cycle
    initial begin
        while (!sim_done) begin
            @(posedge clk);
            #2;
            while (obs_q.size() > 0) begin
                compare_one(obs_q.pop_front());
            end
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        t_tile_id targets [9];
        bit       acked;
        bit       stalled;
        int       accepted;

        rst_n         = 1'b0;
        local_tile_id = TILE;
        in_req        = '0;
        out_rsp       = '0;
        hold          = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            seq[p] = 0;
        end

        // Idle bus during and after reset
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (10) begin
            @(posedge clk);
            #1;
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (out_req[k].stb || out_req[k].cyc || in_rsp[k].ack) begin
                    stop_on_error("a strobe or ack was high after reset with no stimulus");
                end
            end
        end

        // Eight directions around [2,2], then [2,2] itself
        test_name = "local_injection";
        targets = '{'{4'd2, 4'd1}, '{4'd2, 4'd3}, '{4'd1, 4'd2}, '{4'd3, 4'd2},
                    '{4'd1, 4'd1}, '{4'd3, 4'd1}, '{4'd1, 4'd3}, '{4'd3, 4'd3},
                    '{4'd2, 4'd2}};
        for (int i = 0; i < 9; i++) begin
            send_ok(4, make_addr(targets[i]), NULL_CARDINAL);
        end
        wait_drain(500);

        test_name = "transit";
        fork
            burst(0, 10, NULL_CARDINAL);
            burst(1, 10, NULL_CARDINAL);
            burst(2, 10, NULL_CARDINAL);
            burst(3, 10, NULL_CARDINAL);
        join
        wait_drain(1000);

        // Everyone to the south output at once
        test_name = "all_to_one";
        fork
            burst(0, 8, SOUTH);
            burst(1, 8, SOUTH);
            burst(2, 8, SOUTH);
            burst(3, 8, SOUTH);
            burst(4, 8, SOUTH);
        join
        wait_drain(2000);

        // West held, north input feeds it while east keeps using north
        test_name = "back_pressure";
        hold[3]   = 1'b1;
        accepted  = 0;
        stalled   = 1'b0;
        fork
            begin
                while (!stalled && accepted < 4 * FIFO_DEPTH) begin
                    send_one(0, make_addr(t_tile_id'(rand_bits(8))), WEST, STALL_LIMIT, acked);
                    if (acked) begin
                        accepted++;
                    end else begin
                        stalled = 1'b1;
                    end
                end
            end
            burst(1, 6, NORTH);
        join
        if (!stalled) begin
            stop_on_error("input kept accepting requests while its output was held");
        end
        if (accepted > FIFO_DEPTH + 1) begin
            stop_on_error($sformatf("input accepted %0d requests behind a held output, limit %0d",
                accepted, FIFO_DEPTH + 1));
        end
        // East traffic must finish while west is still held
        for (int c = 0; c < 500 && exp_q[1].size() != 0; c++) begin
            @(posedge clk);
        end
        if (exp_q[1].size() != 0) begin
            stop_on_error("another output stopped delivering while one output was held");
        end
        hold[3] = 1'b0;
        wait_ack(0, ACK_LIMIT, acked);
        if (!acked) begin
            stop_on_error("the waiting request was never acked after release");
        end
        burst(0, 3, WEST);
        wait_drain(1000);

        sim_done = 1'b1;
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
